//--- Makefile
# Verilator build and run of the dc_bank_top testbench

VERILATOR ?= verilator
TOP       ?= tb_dc_bank_top
FILELIST  ?= dc_bank_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dc_bank_top.f
hw/dcache_conf_pkg.sv
hw/dcache_types_pkg.sv
hw/dc_access_if.sv
hw/dc_port_arbiter.sv
hw/dc_tag_array.sv
hw/dc_data_array.sv
hw/dc_replace_ctrl.sv
hw/dc_bank_array.sv
hw/dc_bank_top.sv
testbench/tb_clock_gen.sv
testbench/tb_dc_bank_top.sv

//--- hw/dc_access_if.sv
`timescale 1ns/1ps

interface dc_access_if #(
  parameter int READ_PORTS = 3,
  parameter int WAYS       = 4,
  parameter int SETS       = 64
) ();
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = $clog2(WAYS);
  localparam int TAG_W   = PADDR_W - OFFSET_W - INDEX_W;

  // stage 0, array access
  logic               acc_valid;
  logic               acc_wr;
  logic [INDEX_W-1:0] acc_index;
  logic [WAY_W-1:0]   acc_way;
  logic [TAG_W-1:0]   acc_tag;
  line_be_t           acc_be;
  line_t              acc_data;

  // stage 1, per port status
  logic [READ_PORTS-1:0] s1_owner;
  logic [READ_PORTS-1:0] s1_conflict;
  logic [TAG_W-1:0]      s1_tag [READ_PORTS];
  logic                  s1_sel_valid;
  logic [READ_PORTS-1:0] s1_sel_port_owner;
  logic [INDEX_W-1:0]    s1_index;

  modport arb (
    output acc_valid, acc_wr, acc_index, acc_way, acc_tag, acc_be, acc_data,
    output s1_owner, s1_conflict, s1_tag, s1_sel_valid, s1_sel_port_owner, s1_index
  );

  modport array (
    input acc_valid, acc_wr, acc_index, acc_way, acc_tag, acc_be, acc_data,
    input s1_owner, s1_conflict, s1_tag, s1_sel_valid, s1_sel_port_owner, s1_index
  );

endinterface

//--- hw/dc_bank_array.sv
`timescale 1ns/1ps

module dc_bank_array #(
  parameter int READ_PORTS = 3,
  parameter int WAYS       = 4,
  parameter int SETS       = 64
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  dc_access_if.array               acc,
  output logic [READ_PORTS-1:0]    o_rd_hit,
  output logic [READ_PORTS-1:0]    o_rd_miss,
  output logic [READ_PORTS-1:0]    o_rd_conflict,
  output logic [$clog2(WAYS)-1:0]  o_rd_hit_way [READ_PORTS],
  output dcache_types_pkg::line_t  o_rd_data [READ_PORTS],
  output logic                     o_rpl_valid,
  output logic [$clog2(WAYS)-1:0]  o_rpl_way,
  output dcache_types_pkg::paddr_t o_rpl_paddr,
  output dcache_types_pkg::line_t  o_rpl_data
);
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = $clog2(WAYS);
  localparam int TAG_W   = PADDR_W - OFFSET_W - INDEX_W;

  logic [TAG_W-1:0]      w_tag [WAYS];
  logic [WAYS-1:0]       w_tag_valid;
  line_t                 w_data [WAYS];
  logic [READ_PORTS-1:0] w_miss;
  logic [WAY_W-1:0]      w_victim_way;
  logic                  w_sel_miss;
  logic                  w_wr;

  assign w_wr = acc.acc_valid & acc.acc_wr;

  dc_tag_array #(
    .WAYS  (WAYS),
    .SETS  (SETS),
    .TAG_W (TAG_W)
  ) u_tag (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_wr),
    .i_way     (acc.acc_way),
    .i_index   (acc.acc_index),
    .i_tag     (acc.acc_tag),
    .o_tag     (w_tag),
    .o_valid   (w_tag_valid)
  );

  dc_data_array #(
    .WAYS (WAYS),
    .SETS (SETS)
  ) u_data (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_wr),
    .i_way     (acc.acc_way),
    .i_index   (acc.acc_index),
    .i_be      (acc.acc_be),
    .i_data    (acc.acc_data),
    .o_data    (w_data)
  );

  for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
    logic [WAYS-1:0]  w_tag_hit;
    logic [WAY_W-1:0] w_hit_way;

    for (genvar w = 0; w < WAYS; w++) begin : g_cmp
      assign w_tag_hit[w] = w_tag_valid[w] & (w_tag[w] == acc.s1_tag[p]);
    end

    // one valid way at most can match
    always_comb begin
      w_hit_way = '0;
      for (int w = 0; w < WAYS; w++) begin
        if (w_tag_hit[w]) begin
          w_hit_way = WAY_W'(w);
        end
      end
    end

    assign o_rd_hit[p]      = acc.s1_owner[p] & (|w_tag_hit);
    assign w_miss[p]        = acc.s1_owner[p] & ~(|w_tag_hit);
    assign o_rd_conflict[p] = acc.s1_conflict[p];
    assign o_rd_hit_way[p]  = w_hit_way;
    assign o_rd_data[p]     = w_data[w_hit_way];
  end

  assign o_rd_miss = w_miss;

  // only the selected port moves the victim pointer
  assign w_sel_miss = acc.s1_sel_valid & (|(acc.s1_sel_port_owner & w_miss));

  dc_replace_ctrl #(
    .WAYS (WAYS),
    .SETS (SETS)
  ) u_replace (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_index      (acc.s1_index),
    .i_advance    (w_sel_miss),
    .o_victim_way (w_victim_way)
  );

  // victim line rebuilt from its tag and the selected set
  assign o_rpl_valid = w_sel_miss & w_tag_valid[w_victim_way];
  assign o_rpl_way   = w_victim_way;
  assign o_rpl_paddr = {w_tag[w_victim_way], acc.s1_index, {OFFSET_W{1'b0}}};
  assign o_rpl_data  = w_data[w_victim_way];

endmodule

//--- hw/dc_bank_top.sv
`timescale 1ns/1ps

module dc_bank_top #(
  parameter int READ_PORTS = dcache_conf_pkg::DC_READ_PORTS,
  parameter int WAYS       = dcache_conf_pkg::DC_WAYS,
  parameter int SETS       = dcache_conf_pkg::DC_SETS
) (
  input  logic                                              i_clk,
  input  logic                                              i_reset_n,
  input  logic [READ_PORTS-1:0]                             i_rd_valid,
  input  logic [READ_PORTS-1:0]                             i_rd_h_pri,
  input  logic [READ_PORTS*dcache_conf_pkg::PADDR_W-1:0]    i_rd_paddr,
  input  logic                                              i_wr_valid,
  input  logic [$clog2(WAYS)-1:0]                           i_wr_way,
  input  logic [dcache_conf_pkg::PADDR_W-1:0]               i_wr_paddr,
  input  logic [dcache_conf_pkg::LINE_BYTES-1:0]            i_wr_be,
  input  logic [dcache_conf_pkg::LINE_W-1:0]                i_wr_data,
  output logic [READ_PORTS-1:0]                             o_rd_hit,
  output logic [READ_PORTS-1:0]                             o_rd_miss,
  output logic [READ_PORTS-1:0]                             o_rd_conflict,
  output logic [READ_PORTS*$clog2(WAYS)-1:0]                o_rd_hit_way,
  output logic [READ_PORTS*dcache_conf_pkg::LINE_W-1:0]     o_rd_data,
  output logic                                              o_rpl_valid,
  output logic [$clog2(WAYS)-1:0]                           o_rpl_way,
  output logic [dcache_conf_pkg::PADDR_W-1:0]               o_rpl_paddr,
  output logic [dcache_conf_pkg::LINE_W-1:0]                o_rpl_data
);
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  localparam int WAY_W = $clog2(WAYS);

  paddr_t           w_rd_paddr [READ_PORTS];
  logic [WAY_W-1:0] w_rd_hit_way [READ_PORTS];
  line_t            w_rd_data [READ_PORTS];

  // flat port vectors to per port arrays
  for (genvar p = 0; p < READ_PORTS; p++) begin : g_flat
    assign w_rd_paddr[p]                     = i_rd_paddr[p*PADDR_W +: PADDR_W];
    assign o_rd_hit_way[p*WAY_W +: WAY_W]    = w_rd_hit_way[p];
    assign o_rd_data[p*LINE_W +: LINE_W]     = w_rd_data[p];
  end

  dc_access_if #(
    .READ_PORTS (READ_PORTS),
    .WAYS       (WAYS),
    .SETS       (SETS)
  ) u_acc ();

  dc_port_arbiter #(
    .READ_PORTS (READ_PORTS),
    .SETS       (SETS),
    .WAYS       (WAYS)
  ) u_arbiter (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_valid (i_rd_valid),
    .i_rd_h_pri (i_rd_h_pri),
    .i_rd_paddr (w_rd_paddr),
    .i_wr_valid (i_wr_valid),
    .i_wr_way   (i_wr_way),
    .i_wr_paddr (i_wr_paddr),
    .i_wr_be    (i_wr_be),
    .i_wr_data  (i_wr_data),
    .acc        (u_acc.arb)
  );

  dc_bank_array #(
    .READ_PORTS (READ_PORTS),
    .WAYS       (WAYS),
    .SETS       (SETS)
  ) u_bank (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .acc           (u_acc.array),
    .o_rd_hit      (o_rd_hit),
    .o_rd_miss     (o_rd_miss),
    .o_rd_conflict (o_rd_conflict),
    .o_rd_hit_way  (w_rd_hit_way),
    .o_rd_data     (w_rd_data),
    .o_rpl_valid   (o_rpl_valid),
    .o_rpl_way     (o_rpl_way),
    .o_rpl_paddr   (o_rpl_paddr),
    .o_rpl_data    (o_rpl_data)
  );

endmodule

//--- hw/dc_data_array.sv
`timescale 1ns/1ps

module dc_data_array #(
  parameter int WAYS = 4,
  parameter int SETS = 64
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_wr,
  input  logic [$clog2(WAYS)-1:0]    i_way,
  input  logic [$clog2(SETS)-1:0]    i_index,
  input  dcache_types_pkg::line_be_t i_be,
  input  dcache_types_pkg::line_t    i_data,
  output dcache_types_pkg::line_t    o_data [WAYS]
);
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  line_t r_mem [WAYS][SETS];

  // byte merge into the addressed way only
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (i_be[b]) begin
          r_mem[i_way][i_index][b*8 +: 8] <= i_data[b*8 +: 8];
        end
      end
    end
  end

  // read port register, every way at the index
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < WAYS; w++) begin
        o_data[w] <= '0;
      end
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        o_data[w] <= r_mem[w][i_index];
      end
    end
  end

endmodule

//--- hw/dc_port_arbiter.sv
`timescale 1ns/1ps

module dc_port_arbiter #(
  parameter int READ_PORTS = 3,
  parameter int SETS       = 64,
  parameter int WAYS       = 4
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic [READ_PORTS-1:0]      i_rd_valid,
  input  logic [READ_PORTS-1:0]      i_rd_h_pri,
  input  dcache_types_pkg::paddr_t   i_rd_paddr [READ_PORTS],
  input  logic                       i_wr_valid,
  input  logic [$clog2(WAYS)-1:0]    i_wr_way,
  input  dcache_types_pkg::paddr_t   i_wr_paddr,
  input  dcache_types_pkg::line_be_t i_wr_be,
  input  dcache_types_pkg::line_t    i_wr_data,
  dc_access_if.arb                   acc
);
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  localparam int INDEX_W = $clog2(SETS);
  localparam int TAG_W   = PADDR_W - OFFSET_W - INDEX_W;

  logic [READ_PORTS-1:0] w_hpri_req;
  logic [READ_PORTS-1:0] w_hpri_oh;
  logic [READ_PORTS-1:0] w_norm_oh;
  logic [READ_PORTS-1:0] w_sel_oh;
  logic [READ_PORTS-1:0] w_same_index;
  paddr_t                w_sel_paddr;
  paddr_t                w_acc_paddr;

  // lowest set bit, high priority requests first
  assign w_hpri_req = i_rd_valid & i_rd_h_pri;
  assign w_hpri_oh  = w_hpri_req & (~w_hpri_req + 1'b1);
  assign w_norm_oh  = i_rd_valid & (~i_rd_valid + 1'b1);
  assign w_sel_oh   = (|w_hpri_oh) ? w_hpri_oh : w_norm_oh;

  always_comb begin
    w_sel_paddr = '0;
    for (int p = 0; p < READ_PORTS; p++) begin
      w_sel_paddr = w_sel_paddr | ({PADDR_W{w_sel_oh[p]}} & i_rd_paddr[p]);
    end
  end

  // refill write takes the arrays over any read
  assign w_acc_paddr = i_wr_valid ? i_wr_paddr : w_sel_paddr;

  assign acc.acc_valid = i_wr_valid | (|i_rd_valid);
  assign acc.acc_wr    = i_wr_valid;
  assign acc.acc_index = w_acc_paddr[OFFSET_W +: INDEX_W];
  assign acc.acc_tag   = w_acc_paddr[PADDR_W-1 -: TAG_W];
  assign acc.acc_way   = i_wr_way;
  assign acc.acc_be    = i_wr_be;
  assign acc.acc_data  = i_wr_data;

  // ports sharing the selected set ride along on the same lookup
  for (genvar p = 0; p < READ_PORTS; p++) begin : g_same
    assign w_same_index[p] =
      i_rd_paddr[p][OFFSET_W +: INDEX_W] == w_sel_paddr[OFFSET_W +: INDEX_W];
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      acc.s1_owner          <= '0;
      acc.s1_conflict       <= '0;
      acc.s1_sel_valid      <= 1'b0;
      acc.s1_sel_port_owner <= '0;
      acc.s1_index          <= '0;
    end else begin
      acc.s1_owner          <= i_rd_valid & (w_sel_oh | w_same_index) & {READ_PORTS{!i_wr_valid}};
      acc.s1_conflict       <= i_rd_valid &
                               ({READ_PORTS{i_wr_valid}} | ~(w_sel_oh | w_same_index));
      acc.s1_sel_valid      <= (|i_rd_valid) & !i_wr_valid;
      acc.s1_sel_port_owner <= w_sel_oh & {READ_PORTS{!i_wr_valid}};
      acc.s1_index          <= w_sel_paddr[OFFSET_W +: INDEX_W];
    end
  end

  // per port tags for the stage 1 compare
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < READ_PORTS; p++) begin
      acc.s1_tag[p] <= i_rd_paddr[p][PADDR_W-1 -: TAG_W];
    end
  end

endmodule

//--- hw/dc_replace_ctrl.sv
`timescale 1ns/1ps

module dc_replace_ctrl #(
  parameter int WAYS = 4,
  parameter int SETS = 64
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [$clog2(SETS)-1:0] i_index,
  input  logic                    i_advance,
  output logic [$clog2(WAYS)-1:0] o_victim_way
);

  localparam int WAY_W = $clog2(WAYS);

  logic [WAY_W-1:0] r_ptr [SETS];

  // current victim of the looked-up set
  assign o_victim_way = r_ptr[i_index];

  // round robin, wraps after the last way
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < SETS; s++) begin
        r_ptr[s] <= '0;
      end
    end else if (i_advance) begin
      if (r_ptr[i_index] == WAY_W'(WAYS - 1)) begin
        r_ptr[i_index] <= '0;
      end else begin
        r_ptr[i_index] <= r_ptr[i_index] + 1'b1;
      end
    end
  end

endmodule

//--- hw/dc_tag_array.sv
`timescale 1ns/1ps

module dc_tag_array #(
  parameter int WAYS  = 4,
  parameter int SETS  = 64,
  parameter int TAG_W = 22
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_wr,
  input  logic [$clog2(WAYS)-1:0] i_way,
  input  logic [$clog2(SETS)-1:0] i_index,
  input  logic [TAG_W-1:0]        i_tag,
  output logic [TAG_W-1:0]        o_tag [WAYS],
  output logic [WAYS-1:0]         o_valid
);

  logic [WAYS-1:0]  r_valid [SETS];
  logic [TAG_W-1:0] r_tag [WAYS][SETS];

  // valid bits clear on reset, so an empty bank always misses
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < SETS; s++) begin
        r_valid[s] <= '0;
      end
      o_valid <= '0;
    end else begin
      if (i_wr) begin
        r_valid[i_index][i_way] <= 1'b1;
      end
      o_valid <= r_valid[i_index];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tag[i_way][i_index] <= i_tag;
    end
    // all ways read together
    for (int w = 0; w < WAYS; w++) begin
      o_tag[w] <= r_tag[w][i_index];
    end
  end

endmodule

//--- hw/dcache_conf_pkg.sv
package dcache_conf_pkg;

  // default bank geometry, overridden through top level parameters
  parameter int DC_WAYS       = 4;
  parameter int DC_SETS       = 64;
  parameter int DC_READ_PORTS = 3;

  // physical address width
  parameter int PADDR_W = 32;

  // line size, 16 bytes per line
  parameter int LINE_W     = 128;
  parameter int LINE_BYTES = LINE_W / 8;

  // byte offset inside a line, lowest address field
  parameter int OFFSET_W = 4;

endpackage

//--- hw/dcache_types_pkg.sv
package dcache_types_pkg;

  // full physical address
  typedef logic [dcache_conf_pkg::PADDR_W-1:0] paddr_t;

  // one cache line of data
  typedef logic [dcache_conf_pkg::LINE_W-1:0] line_t;

  // one enable bit per byte of a line
  typedef logic [dcache_conf_pkg::LINE_BYTES-1:0] line_be_t;

endpackage

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // reset held over a few rising edges, released on a falling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

//--- testbench/tb_dc_bank_top.sv
`timescale 1ns/1ps

module tb_dc_bank_top;
  import dcache_conf_pkg::*;
  import dcache_types_pkg::*;

  localparam int P       = DC_READ_PORTS;
  localparam int WAYS    = DC_WAYS;
  localparam int SETS    = DC_SETS;
  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W   = $clog2(WAYS);
  localparam int TAG_W   = PADDR_W - OFFSET_W - INDEX_W;

  localparam logic [31:0] SEED = 32'hd09adeeb;

  // response codes of the reference model
  localparam logic [1:0] RESP_NONE     = 2'd0;
  localparam logic [1:0] RESP_HIT      = 2'd1;
  localparam logic [1:0] RESP_MISS     = 2'd2;
  localparam logic [1:0] RESP_CONFLICT = 2'd3;

  // cycles per test section
  localparam int RESET_CYCLES   = 4;
  localparam int N_COLD         = 4;
  localparam int N_REFILL       = 24;
  localparam int N_ARB          = 32;
  localparam int N_WR_CONF      = 4;
  localparam int N_VICTIM       = 13;
  localparam int N_RANDOM       = 400;
  localparam int N_DRAIN        = 2;
  localparam int STIM_CYCLES    = N_COLD + N_REFILL + N_ARB + N_WR_CONF + N_VICTIM
                                  + N_RANDOM + N_DRAIN;
  localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + RESET_CYCLES);

  logic                  clk;
  logic                  reset_n;
  logic [P-1:0]          rd_valid;
  logic [P-1:0]          rd_h_pri;
  logic [P*PADDR_W-1:0]  rd_paddr;
  logic                  wr_valid;
  logic [WAY_W-1:0]      wr_way;
  paddr_t                wr_paddr;
  line_be_t              wr_be;
  line_t                 wr_data;
  logic [P-1:0]          rd_hit;
  logic [P-1:0]          rd_miss;
  logic [P-1:0]          rd_conflict;
  logic [P*WAY_W-1:0]    rd_hit_way;
  logic [P*LINE_W-1:0]   rd_data;
  logic                  rpl_valid;
  logic [WAY_W-1:0]      rpl_way;
  paddr_t                rpl_paddr;
  line_t                 rpl_data;

  // reference model of the bank contents
  logic [TAG_W-1:0] m_tag [SETS][WAYS];
  logic             m_valid [SETS][WAYS];
  line_t            m_data [SETS][WAYS];
  logic [WAY_W-1:0] m_ptr [SETS];

  // expected responses in two slots by cycle parity
  int               exp_tag [2] = '{-10, -10};
  logic [P-1:0]     exp_hit [2];
  logic [P-1:0]     exp_miss [2];
  logic [P-1:0]     exp_conf [2];
  logic [WAY_W-1:0] exp_way [2][P];
  line_t            exp_data [2][P];
  logic             exp_sel_miss [2];
  logic             exp_rpl_valid [2];
  logic [WAY_W-1:0] exp_rpl_way [2];
  paddr_t           exp_rpl_paddr [2];
  line_t            exp_rpl_data [2];

  int errors    = 0;
  int cyc_count = 0;

  tb_clock_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (RESET_CYCLES)
  ) clock_gen_i (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  dc_bank_top #(
    .READ_PORTS (P),
    .WAYS       (WAYS),
    .SETS       (SETS)
  ) dc_bank_top_i (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_rd_valid    (rd_valid),
    .i_rd_h_pri    (rd_h_pri),
    .i_rd_paddr    (rd_paddr),
    .i_wr_valid    (wr_valid),
    .i_wr_way      (wr_way),
    .i_wr_paddr    (wr_paddr),
    .i_wr_be       (wr_be),
    .i_wr_data     (wr_data),
    .o_rd_hit      (rd_hit),
    .o_rd_miss     (rd_miss),
    .o_rd_conflict (rd_conflict),
    .o_rd_hit_way  (rd_hit_way),
    .o_rd_data     (rd_data),
    .o_rpl_valid   (rpl_valid),
    .o_rpl_way     (rpl_way),
    .o_rpl_paddr   (rpl_paddr),
    .o_rpl_data    (rpl_data)
  );

  function automatic logic [INDEX_W-1:0] idx_of(input paddr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] tag_of(input paddr_t addr);
    return addr[PADDR_W-1 -: TAG_W];
  endfunction

  function automatic paddr_t port_addr(input int p);
    return rd_paddr[p*PADDR_W +: PADDR_W];
  endfunction

  // offset bits are ignored by the bank
  function automatic paddr_t make_addr(input logic [TAG_W-1:0] tag,
                                       input logic [INDEX_W-1:0] idx);
    return {tag, idx, OFFSET_W'($urandom)};
  endfunction

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic int find_way(input logic [INDEX_W-1:0] idx,
                                  input logic [TAG_W-1:0] tag);
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) return w;
    end
    return -1;
  endfunction

  // high priority ports win first, then the lowest number
  function automatic int select_port();
    int sel_any;
    int sel_hpri;
    sel_any  = -1;
    sel_hpri = -1;
    for (int p = P - 1; p >= 0; p--) begin
      if (rd_valid[p]) sel_any = p;
      if (rd_valid[p] && rd_h_pri[p]) sel_hpri = p;
    end
    return (sel_hpri >= 0) ? sel_hpri : sel_any;
  endfunction

  function automatic logic [1:0] predict_port(input int p, input int sel,
                                              output logic [WAY_W-1:0] way,
                                              output line_t data);
    logic [INDEX_W-1:0] idx;
    int                 hit_way;
    way  = '0;
    data = '0;
    if (!rd_valid[p]) return RESP_NONE;
    if (wr_valid) return RESP_CONFLICT;
    idx = idx_of(port_addr(p));
    if (p != sel && idx != idx_of(port_addr(sel))) return RESP_CONFLICT;
    hit_way = find_way(idx, tag_of(port_addr(p)));
    if (hit_way < 0) return RESP_MISS;
    way  = WAY_W'(hit_way);
    data = m_data[idx][hit_way];
    return RESP_HIT;
  endfunction

  task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                             input logic [LINE_W-1:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h (cycle %0d)",
               name, actual, expected, cyc_count);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic set_idle();
    rd_valid = '0;
    rd_h_pri = '0;
    rd_paddr = '0;
    wr_valid = 1'b0;
    wr_way   = '0;
    wr_paddr = '0;
    wr_be    = '0;
    wr_data  = '0;
  endtask

  task automatic issue_read(input int p, input paddr_t addr, input logic hpri);
    rd_valid[p]                  = 1'b1;
    rd_h_pri[p]                  = hpri;
    rd_paddr[p*PADDR_W +: PADDR_W] = addr;
  endtask

  task automatic issue_write(input logic [WAY_W-1:0] way, input paddr_t addr,
                             input line_be_t be, input line_t data);
    wr_valid = 1'b1;
    wr_way   = way;
    wr_paddr = addr;
    wr_be    = be;
    wr_data  = data;
  endtask

  // predict this cycle's responses and then update the model
  task automatic commit();
    int                 sel;
    int                 slot;
    logic [1:0]         resp;
    logic [WAY_W-1:0]   way;
    line_t              data;
    logic [INDEX_W-1:0] idx;
    logic               sel_miss;
    sel      = select_port();
    slot     = cyc_count % 2;
    sel_miss = 1'b0;
    exp_tag[slot] = cyc_count;
    for (int p = 0; p < P; p++) begin
      resp = predict_port(p, sel, way, data);
      exp_hit[slot][p]  = (resp == RESP_HIT);
      exp_miss[slot][p] = (resp == RESP_MISS);
      exp_conf[slot][p] = (resp == RESP_CONFLICT);
      exp_way[slot][p]  = way;
      exp_data[slot][p] = data;
      if (p == sel && resp == RESP_MISS) sel_miss = 1'b1;
    end
    // victim of the selected set with the pointer before it moves
    idx = (sel >= 0) ? idx_of(port_addr(sel)) : '0;
    exp_sel_miss[slot]  = sel_miss;
    exp_rpl_valid[slot] = sel_miss && m_valid[idx][m_ptr[idx]];
    exp_rpl_way[slot]   = m_ptr[idx];
    exp_rpl_paddr[slot] = {m_tag[idx][m_ptr[idx]], idx, OFFSET_W'(0)};
    exp_rpl_data[slot]  = m_data[idx][m_ptr[idx]];
    if (sel_miss) m_ptr[idx] = WAY_W'((int'(m_ptr[idx]) + 1) % WAYS);
    if (wr_valid) begin
      idx = idx_of(wr_paddr);
      m_valid[idx][wr_way] = 1'b1;
      m_tag[idx][wr_way]   = tag_of(wr_paddr);
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_be[b]) m_data[idx][wr_way][b*8 +: 8] = wr_data[b*8 +: 8];
      end
    end
  endtask

  task automatic run_cycle();
    commit();
    @(negedge clk);
    set_idle();
  endtask

  task automatic cold_misses();
    for (int c = 0; c < N_COLD; c++) begin
      for (int p = 0; p < P; p++) begin
        issue_read(p, make_addr(TAG_W'($urandom), INDEX_W'(c)), 1'($urandom_range(1)));
      end
      run_cycle();
    end
  endtask

  task automatic refill_and_hit();
    for (int s = 8; s < 10; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        issue_write(WAY_W'(w), make_addr(TAG_W'(22'h100 + w), INDEX_W'(s)), '1, rand_line());
        run_cycle();
      end
      // partial refills merge into the lines
      for (int w = 0; w < WAYS; w++) begin
        issue_write(WAY_W'(w), make_addr(TAG_W'(22'h100 + w), INDEX_W'(s)),
                    line_be_t'($urandom), rand_line());
        run_cycle();
      end
      for (int w = 0; w < WAYS; w++) begin
        issue_read(w % P, make_addr(TAG_W'(22'h100 + w), INDEX_W'(s)), 1'b0);
        run_cycle();
      end
    end
  endtask

  task automatic port_arbitration();
    for (int c = 0; c < N_ARB; c++) begin
      for (int p = 0; p < P; p++) begin
        if ($urandom_range(3) != 0) begin
          issue_read(p, make_addr(TAG_W'(22'h100 + $urandom_range(4)),
                                  INDEX_W'(8 + $urandom_range(1))), 1'($urandom_range(1)));
        end
      end
      run_cycle();
    end
  endtask

  task automatic reads_during_write();
    for (int c = 0; c < N_WR_CONF; c++) begin
      issue_write(WAY_W'(c), make_addr(TAG_W'(22'h150 + c), INDEX_W'(10)), '1, rand_line());
      for (int p = 0; p < P; p++) begin
        issue_read(p, make_addr(TAG_W'(22'h100 + p), INDEX_W'(8 + c % 3)), 1'(p == 2));
      end
      run_cycle();
    end
  endtask

  task automatic victim_rotation();
    for (int c = 0; c < 5; c++) begin
      issue_read(0, make_addr(TAG_W'(22'h200 + c), INDEX_W'(20)), 1'b0);
      run_cycle();
    end
    for (int w = 0; w < WAYS; w++) begin
      issue_write(WAY_W'(w), make_addr(TAG_W'(22'h300 + w), INDEX_W'(20)), '1, rand_line());
      run_cycle();
    end
    for (int c = 0; c < 4; c++) begin
      issue_read(c % P, make_addr(TAG_W'(22'h2ff), INDEX_W'(20)), 1'b1);
      run_cycle();
    end
  endtask

  task automatic random_traffic();
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    int                 way;
    line_be_t           be;
    for (int c = 0; c < N_RANDOM; c++) begin
      if ($urandom_range(3) == 0) begin
        idx = INDEX_W'(30 + $urandom_range(1));
        tag = TAG_W'(22'h3a0 + $urandom_range(5));
        // refill reuses the way that already holds the tag
        way = find_way(idx, tag);
        if (way < 0) way = $urandom_range(WAYS - 1);
        be = m_valid[idx][way] ? line_be_t'($urandom) : '1;
        issue_write(WAY_W'(way), make_addr(tag, idx), be, rand_line());
      end
      for (int p = 0; p < P; p++) begin
        if ($urandom_range(1) == 1) begin
          issue_read(p, make_addr(TAG_W'(22'h3a0 + $urandom_range(5)),
                                  INDEX_W'(30 + $urandom_range(1))), 1'($urandom_range(1)));
        end
      end
      run_cycle();
    end
  endtask

  initial begin
    void'($urandom(SEED));
    set_idle();
    for (int s = 0; s < SETS; s++) begin
      m_ptr[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
    @(posedge reset_n);
    @(negedge clk);
    check_value("o_rd_hit", LINE_W'(rd_hit), '0);
    check_value("o_rd_miss", LINE_W'(rd_miss), '0);
    check_value("o_rd_conflict", LINE_W'(rd_conflict), '0);
    check_value("o_rpl_valid", LINE_W'(rpl_valid), '0);
    cold_misses();
    refill_and_hit();
    port_arbitration();
    reads_during_write();
    victim_rotation();
    random_traffic();
    repeat (N_DRAIN) run_cycle();
    // let the last falling edge compare finish
    @(posedge clk);
    if (errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "errors found");
    end
  end

  // responses are stable at the falling edge after the request edge
  always @(negedge clk) begin : compare_outputs
    int slot;
    slot = (cyc_count + 1) % 2;
    if (exp_tag[slot] == cyc_count - 1) begin
      check_value("o_rd_hit", LINE_W'(rd_hit), LINE_W'(exp_hit[slot]));
      check_value("o_rd_miss", LINE_W'(rd_miss), LINE_W'(exp_miss[slot]));
      check_value("o_rd_conflict", LINE_W'(rd_conflict), LINE_W'(exp_conf[slot]));
      for (int p = 0; p < P; p++) begin
        if (exp_hit[slot][p]) begin
          check_value($sformatf("o_rd_hit_way[%0d]", p),
                      LINE_W'(rd_hit_way[p*WAY_W +: WAY_W]), LINE_W'(exp_way[slot][p]));
          check_value($sformatf("o_rd_data[%0d]", p),
                      rd_data[p*LINE_W +: LINE_W], exp_data[slot][p]);
        end
      end
      check_value("o_rpl_valid", LINE_W'(rpl_valid), LINE_W'(exp_rpl_valid[slot]));
      if (exp_sel_miss[slot]) begin
        check_value("o_rpl_way", LINE_W'(rpl_way), LINE_W'(exp_rpl_way[slot]));
      end
      if (exp_rpl_valid[slot]) begin
        check_value("o_rpl_paddr", LINE_W'(rpl_paddr), LINE_W'(exp_rpl_paddr[slot]));
        check_value("o_rpl_data", rpl_data, exp_rpl_data[slot]);
      end
    end
  end

  always @(posedge clk) begin
    cyc_count = cyc_count + 1;
    if (cyc_count > TIMEOUT_CYCLES) begin
      $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "cycle limit reached");
    end
  end

endmodule
